// File: flist.f
verilog/uart_pkg.sv
verilog/uart_host_if.sv
verilog/uart_wb_decode.sv
verilog/uart_tx_buffer.sv
verilog/uart_tx_serializer.sv
verilog/uart_rx_deserializer.sv
verilog/uart_top.sv
bench/uart_tb.sv

// File: Bender.yml
package:
  name: uart_wb

sources:
  - verilog/uart_pkg.sv
  - verilog/uart_host_if.sv
  - verilog/uart_wb_decode.sv
  - verilog/uart_tx_buffer.sv
  - verilog/uart_tx_serializer.sv
  - verilog/uart_rx_deserializer.sv
  - verilog/uart_top.sv
  - target: test
    files:
      - bench/uart_tb.sv

// File: bench/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

	localparam int CLKS_PER_BIT = 8;
	localparam int N_STEPS      = 24;
	localparam int SEED         = 36190;
	// One long frame budget per table entry
	localparam int LIMIT        = N_STEPS * 12 * 10 * CLKS_PER_BIT;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_POLL,
		OP_BREAK
	} op_t;

	// One table row
	// val holds write data, poll mask or break length in bits
	// exp holds the read value or 1 on a write that must stall
	typedef struct {
		op_t                 op;
		uart_pkg::reg_addr_t adr;
		uart_pkg::byte_t     val;
		uart_pkg::byte_t     exp;
	} step_t;

	logic                clk;
	logic                rst_n;
	logic                cyc;
	logic                stb;
	logic                we;
	uart_pkg::reg_addr_t adr;
	uart_pkg::byte_t     dat_w;
	uart_pkg::byte_t     dat_r;
	logic                ack;
	logic                rxd;
	logic                txd;
	logic                brk;
	int unsigned         cycles = 0;
	step_t               steps [N_STEPS];
	uart_pkg::byte_t     rnd [5];

	// Loopback with the break holding the line low
	assign rxd = brk ? 1'b0 : txd;

	uart_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) dut (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.rxd   (rxd),
		.txd   (txd)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reporting and compares
	//////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// Watchdog on total run length
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= LIMIT)
			abort_run("run timed out waiting for the bus or the receiver");
	end

	function automatic string flag_names(input uart_pkg::byte_t s);
		string t;
		t = "";
		if (s[uart_pkg::STAT_TX_FULL])
			t = {t, " tx_full"};
		if (s[uart_pkg::STAT_RX_VALID])
			t = {t, " rx_valid"};
		if (s[uart_pkg::STAT_OVERRUN])
			t = {t, " overrun"};
		if (s[uart_pkg::STAT_FRAMING])
			t = {t, " framing_err"};
		if (t == "")
			t = " none";
		return t;
	endfunction

	task automatic check_byte(input string name, input uart_pkg::byte_t got,
		input uart_pkg::byte_t exp);
		if (got !== exp)
			abort_run($sformatf("error %s got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic check_status(input uart_pkg::byte_t got, input uart_pkg::byte_t exp);
		if (got !== exp)
			abort_run($sformatf("error dat_r status got 0x%02h (%s ) expected 0x%02h (%s )",
				got, flag_names(got), exp, flag_names(exp)));
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Only a DATA write into a full buffer stalls
	task automatic check_waits(input int waits, input logic stall);
		if (stall && waits == 0)
			abort_run("DATA write was acked with no wait states on a full buffer");
		else if (!stall && waits != 0)
			abort_run($sformatf("bus access was stalled for %0d wait states", waits));
	endtask

	//////////////////////////////////////////////////
	// Bus and table
	//////////////////////////////////////////////////

	// Starts just after a rising edge and ends the same way
	task automatic bus_access(input logic wr, input uart_pkg::reg_addr_t a,
		input uart_pkg::byte_t wdata, output uart_pkg::byte_t rdata,
		output int waits);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = a;
		dat_w = wdata;
		// Ack and dat_r are stable at the falling edge
		// No ack yet in the request cycle
		@(negedge clk);
		check_line("ack", ack, 1'b0);
		waits = 0;
		@(negedge clk);
		while (!ack)
		begin
			waits++;
			@(negedge clk);
		end
		rdata = dat_r;
		@(posedge clk);
		#2;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic put_step(input int i, input op_t op, input uart_pkg::reg_addr_t a,
		input uart_pkg::byte_t v, input uart_pkg::byte_t e);
		steps[i].op  = op;
		steps[i].adr = a;
		steps[i].val = v;
		steps[i].exp = e;
	endtask

	task automatic build_table();
		// Idle status then a single loopback byte
		put_step(0, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h00);
		put_step(1, OP_WRITE, uart_pkg::REG_DATA, rnd[0], 8'h00);
		put_step(2, OP_POLL, uart_pkg::REG_STATUS, 8'h02, 8'h00);
		put_step(3, OP_READ, uart_pkg::REG_DATA, 8'h00, rnd[0]);
		put_step(4, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h00);
		// Three writes in a row
		put_step(5, OP_WRITE, uart_pkg::REG_DATA, rnd[1], 8'h00);
		// These two stall on the holding buffer
		put_step(6, OP_WRITE, uart_pkg::REG_DATA, rnd[2], 8'h01);
		put_step(7, OP_WRITE, uart_pkg::REG_DATA, rnd[3], 8'h01);
		// Second byte overruns the first
		put_step(8, OP_POLL, uart_pkg::REG_STATUS, 8'h04, 8'h00);
		put_step(9, OP_WRITE, uart_pkg::REG_STATUS, 8'h04, 8'h00);
		// Third byte overruns again
		put_step(10, OP_POLL, uart_pkg::REG_STATUS, 8'h04, 8'h00);
		put_step(11, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h06);
		// Clearing overrun leaves rx_valid set
		put_step(12, OP_WRITE, uart_pkg::REG_STATUS, 8'h04, 8'h00);
		put_step(13, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h02);
		put_step(14, OP_READ, uart_pkg::REG_DATA, 8'h00, rnd[3]);
		put_step(15, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h00);
		// Break longer than a frame
		put_step(16, OP_BREAK, uart_pkg::REG_DATA, 8'd12, 8'h00);
		put_step(17, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h08);
		put_step(18, OP_WRITE, uart_pkg::REG_STATUS, 8'h08, 8'h00);
		put_step(19, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h00);
		// Receiver recovers
		put_step(20, OP_WRITE, uart_pkg::REG_DATA, rnd[4], 8'h00);
		put_step(21, OP_POLL, uart_pkg::REG_STATUS, 8'h02, 8'h00);
		put_step(22, OP_READ, uart_pkg::REG_DATA, 8'h00, rnd[4]);
		put_step(23, OP_READ, uart_pkg::REG_STATUS, 8'h00, 8'h00);
	endtask

	task automatic run_step(input step_t s);
		uart_pkg::byte_t rd;
		int              waits;
		case (s.op)
			OP_WRITE:
			begin
				bus_access(1'b1, s.adr, s.val, rd, waits);
				check_waits(waits, s.exp[0]);
			end
			OP_READ:
			begin
				bus_access(1'b0, s.adr, 8'h00, rd, waits);
				check_waits(waits, 1'b0);
				if (s.adr == uart_pkg::REG_DATA)
					check_byte("dat_r", rd, s.exp);
				else
					check_status(rd, s.exp);
			end
			// Repeats until the masked flag is set
			OP_POLL:
				do
				begin
					bus_access(1'b0, uart_pkg::REG_STATUS, 8'h00, rd, waits);
					check_waits(waits, 1'b0);
				end
				while ((rd & s.val) == 8'h00);
			OP_BREAK:
			begin
				brk = 1'b1;
				repeat (s.val * CLKS_PER_BIT) @(posedge clk);
				#2;
				brk = 1'b0;
			end
			default:
				abort_run("table holds an unknown operation");
		endcase
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = uart_pkg::REG_DATA;
		dat_w = 8'h00;
		brk   = 1'b0;
		for (int i = 0; i < 5; i++)
			rnd[i] = uart_pkg::byte_t'($urandom() & 32'hff);
		build_table();
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Idle line after reset
		@(negedge clk);
		check_line("txd", txd, 1'b1);
		@(posedge clk);
		#2;
		for (int i = 0; i < N_STEPS; i++)
			run_step(steps[i]);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: verilog/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  uart_pkg::reg_addr_t adr,
	input  uart_pkg::byte_t     dat_w,
	output uart_pkg::byte_t     dat_r,
	output logic                ack,
	input  logic                rxd,
	output logic                txd
);

	// Buffer to serializer hand-off
	logic            start;
	logic            busy;
	uart_pkg::byte_t data;

	uart_host_if host ();

	////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////

	uart_wb_decode u_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.host  (host.decode)
	);

	uart_tx_buffer u_tx_buffer (
		.clk   (clk),
		.rst_n (rst_n),
		.host  (host.tx),
		.start (start),
		.data  (data),
		.busy  (busy)
	);

	////////////////////////////////////////////////////
	// Line side
	////////////////////////////////////////////////////

	uart_tx_serializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx_serializer (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.data  (data),
		.busy  (busy),
		.txd   (txd)
	);

	uart_rx_deserializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx_deserializer (
		.clk   (clk),
		.rst_n (rst_n),
		.rxd   (rxd),
		.host  (host.rx)
	);

endmodule

// File: verilog/uart_rx_deserializer.sv
`timescale 1ns/1ps

module uart_rx_deserializer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    rxd,
	uart_host_if.rx host
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	uart_pkg::rx_state_t state;
	logic [1:0]          sync;
	logic                rx_s;
	logic                rx_d;
	logic [CW-1:0]       clk_cnt;
	logic [2:0]          bit_cnt;
	logic                bit_end;
	logic                half_end;
	logic                stop_ok;
	uart_pkg::byte_t     shreg;

	// Two-flop synchronizer, idle high
	assign rx_s = sync[1];

	assign bit_end  = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign half_end = (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1));

	// Good frame ends here
	assign stop_ok = (state == uart_pkg::RX_STOP) && bit_end && rx_s;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync <= 2'b11;
			rx_d <= 1'b1;
		end
		else
		begin
			sync <= {sync[0], rxd};
			rx_d <= rx_s;
		end
	end

	////////////////////////////////////////////////////
	// Frame receiver
	////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= uart_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				// Falling edge only, so a stuck-low line is not re-hunted
				uart_pkg::RX_IDLE:
				begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					if (!rx_s && rx_d)
						state <= uart_pkg::RX_START;
				end
				// Mid start bit, reject glitches
				uart_pkg::RX_START:
					if (half_end)
					begin
						clk_cnt <= '0;
						state   <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end
				uart_pkg::RX_DATA:
					if (bit_end)
					begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= uart_pkg::RX_STOP;
					end
				uart_pkg::RX_STOP:
					if (bit_end)
						state <= uart_pkg::RX_IDLE;
				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits enter at the top, LSB first
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::RX_DATA && bit_end)
			shreg <= {rx_s, shreg[7:1]};
		if (stop_ok)
			host.rx_data <= shreg;
	end

	////////////////////////////////////////////////////
	// Status flags
	////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			host.rx_valid    <= 1'b0;
			host.overrun     <= 1'b0;
			host.framing_err <= 1'b0;
		end
		else
		begin
			// Clears first, a new event wins
			if (host.rx_rd)
				host.rx_valid <= 1'b0;
			if (host.clr_overrun)
				host.overrun <= 1'b0;
			if (host.clr_framing)
				host.framing_err <= 1'b0;
			if (stop_ok)
			begin
				host.rx_valid <= 1'b1;
				// Unread byte gets replaced
				if (host.rx_valid && !host.rx_rd)
					host.overrun <= 1'b1;
			end
			// Low stop bit, byte dropped
			if (state == uart_pkg::RX_STOP && bit_end && !rx_s)
				host.framing_err <= 1'b1;
		end
	end

endmodule

// File: verilog/uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  uart_pkg::byte_t data,
	output logic            busy,
	output logic            txd
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	uart_pkg::tx_state_t state;
	logic [CW-1:0]       clk_cnt;
	logic [2:0]          bit_cnt;
	logic                bit_end;
	uart_pkg::byte_t     shreg;

	// Last cycle of the current bit period
	assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign busy    = (state != uart_pkg::TX_IDLE);

	////////////////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= uart_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			txd     <= 1'b1;
		end
		else
		begin
			// Free-running bit timer while a frame is out
			if (state == uart_pkg::TX_IDLE || bit_end)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;
			case (state)
				uart_pkg::TX_IDLE:
				begin
					bit_cnt <= '0;
					if (start)
					begin
						state <= uart_pkg::TX_START;
						txd   <= 1'b0;
					end
				end
				uart_pkg::TX_START:
					if (bit_end)
					begin
						state <= uart_pkg::TX_DATA;
						txd   <= shreg[0];
					end
				// LSB first
				uart_pkg::TX_DATA:
					if (bit_end)
					begin
						if (bit_cnt == 3'd7)
						begin
							state <= uart_pkg::TX_STOP;
							txd   <= 1'b1;
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							txd     <= shreg[0];
						end
					end
				uart_pkg::TX_STOP:
					if (bit_end)
						state <= uart_pkg::TX_IDLE;
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// Shift register, next bit always at position 0
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::TX_IDLE && start)
			shreg <= data;
		else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA))
			shreg <= shreg >> 1;
	end

	// Buffer hands over only between frames
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: verilog/uart_tx_buffer.sv
`timescale 1ns/1ps

module uart_tx_buffer (
	input  logic            clk,
	input  logic            rst_n,
	uart_host_if.tx         host,
	output logic            start,
	output uart_pkg::byte_t data,
	input  logic            busy
);

	uart_pkg::buf_state_t state;
	uart_pkg::buf_state_t state_nxt;

	// Moore outputs
	assign host.tx_full = (state != uart_pkg::BUF_EMPTY);
	assign start        = (state == uart_pkg::BUF_HANDOFF);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= uart_pkg::BUF_EMPTY;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			uart_pkg::BUF_EMPTY:
				if (host.tx_wr)
					state_nxt = uart_pkg::BUF_HELD;
			// Wait out the frame in flight
			uart_pkg::BUF_HELD:
				if (!busy)
					state_nxt = uart_pkg::BUF_HANDOFF;
			uart_pkg::BUF_HANDOFF:
				state_nxt = uart_pkg::BUF_EMPTY;
			default:
				state_nxt = uart_pkg::BUF_EMPTY;
		endcase
	end

	// Held byte, loaded only while empty
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::BUF_EMPTY && host.tx_wr)
			data <= host.tx_data;
	end

	// Decoder must hold off writes while a byte is held
	a_no_wr_when_full: assert property (
		@(posedge clk) disable iff (!rst_n) host.tx_wr |-> !host.tx_full
	);

endmodule

// File: verilog/uart_wb_decode.sv
`timescale 1ns/1ps

module uart_wb_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  uart_pkg::reg_addr_t  adr,
	input  uart_pkg::byte_t      dat_w,
	output uart_pkg::byte_t      dat_r,
	output logic                 ack,
	uart_host_if.decode          host
);

	logic            data_wr;
	logic            take;
	uart_pkg::byte_t status;

	// Write to DATA stalls while the buffer is full
	assign data_wr = we && (adr == uart_pkg::REG_DATA);

	// Accept once per cycle, never in the ack cycle itself
	assign take = cyc && stb && !ack && !(data_wr && host.tx_full);

	// Status word, unused bits read as zero
	always_comb
	begin
		status = '0;
		status[uart_pkg::STAT_TX_FULL]  = host.tx_full;
		status[uart_pkg::STAT_RX_VALID] = host.rx_valid;
		status[uart_pkg::STAT_OVERRUN]  = host.overrun;
		status[uart_pkg::STAT_FRAMING]  = host.framing_err;
	end

	////////////////////////////////////////////////////
	// Ack and side-effect strobes
	////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ack              <= 1'b0;
			host.tx_wr       <= 1'b0;
			host.rx_rd       <= 1'b0;
			host.clr_overrun <= 1'b0;
			host.clr_framing <= 1'b0;
		end
		else
		begin
			ack        <= take;
			host.tx_wr <= take && data_wr;
			// Reading DATA pops the received byte
			host.rx_rd <= take && !we && (adr == uart_pkg::REG_DATA);
			// Write-one-to-clear on STATUS
			host.clr_overrun <= take && we && (adr == uart_pkg::REG_STATUS)
				&& dat_w[uart_pkg::STAT_OVERRUN];
			host.clr_framing <= take && we && (adr == uart_pkg::REG_STATUS)
				&& dat_w[uart_pkg::STAT_FRAMING];
		end
	end

	// Payload, only meaningful next to its strobe
	always_ff @(posedge clk)
	begin
		if (take && data_wr)
			host.tx_data <= dat_w;
		if (take && !we)
			dat_r <= (adr == uart_pkg::REG_DATA) ? host.rx_data : status;
	end

	// Single-cycle ack per bus cycle
	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack);

endmodule

// File: verilog/uart_host_if.sv
`timescale 1ns/1ps

interface uart_host_if;

	// Transmit side
	uart_pkg::byte_t tx_data;
	logic            tx_wr;
	logic            tx_full;

	// Receive side
	uart_pkg::byte_t rx_data;
	logic            rx_valid;
	logic            rx_rd;

	// Error flags and their clear strobes
	logic            clr_overrun;
	logic            clr_framing;
	logic            overrun;
	logic            framing_err;

	// Bus decoder drives all strobes
	modport decode (
		output tx_data, tx_wr, rx_rd, clr_overrun, clr_framing,
		input  tx_full, rx_data, rx_valid, overrun, framing_err
	);

	// Holding buffer
	modport tx (
		input  tx_data, tx_wr,
		output tx_full
	);

	// Receiver, also keeps the flags
	modport rx (
		input  rx_rd, clr_overrun, clr_framing,
		output rx_data, rx_valid, overrun, framing_err
	);

endinterface

// File: verilog/uart_pkg.sv
package uart_pkg;

	////////////////////////////////////////////////////
	// Data and register map
	////////////////////////////////////////////////////

	typedef logic [7:0] byte_t;

	// One address bit, two registers
	typedef enum logic [0:0] {
		REG_DATA   = 1'b0,
		REG_STATUS = 1'b1
	} reg_addr_t;

	// Bit positions in the status word
	localparam int STAT_TX_FULL  = 0;
	localparam int STAT_RX_VALID = 1;
	localparam int STAT_OVERRUN  = 2;
	localparam int STAT_FRAMING  = 3;

	////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		BUF_EMPTY,
		BUF_HELD,
		BUF_HANDOFF
	} buf_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage
